//--- rtl/nnTypesPkg.sv
package nnTypesPkg;

	localparam int NumInputs = 30; // Samples per frame
	localparam int NumHidden = 8;
	localparam int NumClasses = 4;

	localparam int ClassIdxW = $clog2(NumClasses);

	typedef logic signed [7:0] sampleT;

	typedef logic [7:0] actT; // ReLU output, never negative

	typedef sampleT [NumInputs-1:0] frameT;

	typedef actT [NumHidden-1:0] hiddenVecT;

	typedef struct packed
	{
		logic [ClassIdxW-1:0] classIdx;
		actT score;
	} resultT;

endpackage

//--- rtl/nnWeightsPkg.sv
package nnWeightsPkg;

	typedef logic signed [7:0] weightT;

	localparam int TableBits = 4;
	localparam int TableSize = 1 << TableBits;

	// Shared by both layers, each layer walks it with its own stride
	localparam weightT WeightTable [TableSize] = '{
		8'sb11011110,
		8'sb11101110,
		8'sb00010011,
		8'sb00100011,
		8'sb00101111,
		8'sb00111100,
		8'sb11100001,
		8'sb11001111,
		8'sb11110010,
		8'sb00010000,
		8'sb00101101,
		8'sb10111011,
		8'sb01011110,
		8'sb11010000,
		8'sb11000111,
		8'sb11101000
	};

	function automatic weightT tableEntry(int idx);
		return WeightTable[TableBits'(idx % TableSize)];
	endfunction

	function automatic weightT hiddenWeight(int neuron, int inputIdx);
		return tableEntry(neuron * 7 + inputIdx * 3);
	endfunction

	function automatic weightT hiddenBias(int neuron);
		return tableEntry(neuron * 5 + 1);
	endfunction

	function automatic weightT outputWeight(int classNum, int hiddenIdx);
		return tableEntry(classNum * 11 + hiddenIdx * 5 + 2);
	endfunction

	function automatic weightT outputBias(int classNum);
		return tableEntry(classNum * 3 + 9);
	endfunction

endpackage

//--- rtl/sampleCollector.sv
`timescale 1ns/1ps

module sampleCollector (
	input logic clk,
	input logic reset,
	input nnTypesPkg::sampleT sample,
	input logic sampleStrobe,
	output nnTypesPkg::frameT frame,
	output logic frameValid
);
	import nnTypesPkg::*;

	localparam int CountW = $clog2(NumInputs);
	localparam logic [CountW-1:0] LastCount = CountW'(NumInputs - 1);

	sampleT [NumInputs-2:0] shiftReg; // First 29 samples of the frame being built
	logic [CountW-1:0] sampleCount;
	logic lastSample;

	assign lastSample = sampleStrobe && (sampleCount == LastCount);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sampleCount <= '0;
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= lastSample;
			if (sampleStrobe)
				sampleCount <= lastSample ? '0 : sampleCount + 1'b1;
		end
	end

	// New samples enter at the top, so the oldest one settles at index 0
	always_ff @(posedge clk)
	begin
		if (sampleStrobe)
			shiftReg <= {sample, shiftReg[NumInputs-2:1]};
		if (lastSample)
			frame <= {sample, shiftReg}; // Held until the next complete frame
	end

	countInRange: assert property (@(posedge clk) disable iff (reset)
		sampleCount <= LastCount);

endmodule

//--- rtl/neuronNode.sv
`timescale 1ns/1ps

module neuronNode #(
	parameter int NeuronIndex = 0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::frameT frame,
	output nnTypesPkg::actT activation
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	frameT frameReg;
	logic [7:0] sumNext;
	logic [7:0] sumReg;

	// Products keep their low byte only and the sum wraps in 8 bits
	always_comb
	begin
		sumNext = hiddenBias(NeuronIndex);
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + 8'(frameReg[i] * hiddenWeight(NeuronIndex, i));
		end
	end

	always_ff @(posedge clk)
	begin
		frameReg <= frame; // Stage one
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			if (sumReg[7] == 1'b0)
				activation <= sumReg;
			else
				activation <= '0; // ReLU clamp
		end
	end

endmodule

//--- rtl/denseLayer.sv
`timescale 1ns/1ps

module denseLayer (
	input logic clk,
	input logic reset,
	input nnTypesPkg::frameT frame,
	input logic frameValid,
	output nnTypesPkg::hiddenVecT hidden,
	output logic hiddenValid
);
	import nnTypesPkg::*;

	localparam int NodeLatency = 3; // Input, sum and ReLU registers

	logic [NodeLatency-1:0] validPipe;

	for (genvar n = 0; n < NumHidden; n++)
	begin : neuronGen
		neuronNode #(
			.NeuronIndex(n)
		) neuron (
			.clk(clk),
			.reset(reset),
			.frame(frame),
			.activation(hidden[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[NodeLatency-2:0], frameValid};
	end

	assign hiddenValid = validPipe[NodeLatency-1]; // Lines up with the ReLU register

endmodule

//--- rtl/activationBuffer.sv
`timescale 1ns/1ps

module activationBuffer #(
	parameter int BufferDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input nnTypesPkg::hiddenVecT pushData,
	input logic pop,
	output nnTypesPkg::hiddenVecT head,
	output logic empty,
	output logic [7:0] dropCount
);
	import nnTypesPkg::*;

	localparam int PtrW = (BufferDepth > 1) ? $clog2(BufferDepth) : 1;
	localparam int CountW = $clog2(BufferDepth + 1);
	localparam logic [PtrW-1:0] LastPtr = PtrW'(BufferDepth - 1);
	localparam logic [CountW-1:0] FullCount = CountW'(BufferDepth);

	hiddenVecT mem [BufferDepth];
	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrPtr;
	logic [CountW-1:0] occupancy;
	logic full;
	logic popTaken;
	logic pushTaken;

	assign empty = (occupancy == '0);
	assign full = (occupancy == FullCount);
	assign popTaken = pop && !empty;
	assign pushTaken = push && (!full || popTaken); // A pop frees the slot in the same cycle
	assign head = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (pushTaken)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			occupancy <= '0;
			dropCount <= '0;
		end
		else
		begin
			if (pushTaken)
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
			if (popTaken)
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
			if (pushTaken && !popTaken)
				occupancy <= occupancy + 1'b1;
			else if (popTaken && !pushTaken)
				occupancy <= occupancy - 1'b1;
			if (push && !pushTaken && dropCount != 8'hFF)
				dropCount <= dropCount + 1'b1; // Sticks at 255
		end
	end

	noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

	occupancyBound: assert property (@(posedge clk) disable iff (reset)
		occupancy <= FullCount);

endmodule

//--- rtl/outputClassifier.sv
`timescale 1ns/1ps

module outputClassifier (
	input logic clk,
	input logic reset,
	input nnTypesPkg::hiddenVecT head,
	input logic empty,
	output logic pop,
	output nnTypesPkg::resultT result,
	output logic resultValid
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	localparam int HiddenIdxW = $clog2(NumHidden);
	localparam logic [HiddenIdxW-1:0] LastHidden = HiddenIdxW'(NumHidden - 1);
	localparam logic [ClassIdxW-1:0] LastClass = ClassIdxW'(NumClasses - 1);

	typedef enum logic [1:0] {Idle, Accum, Finish} stateT;

	stateT state;
	hiddenVecT vecReg;
	logic [HiddenIdxW-1:0] hiddenCnt;
	logic [ClassIdxW-1:0] classCnt;
	logic [7:0] acc;
	logic [7:0] weightBits;
	logic [7:0] product;
	logic [7:0] classSum;
	actT classScore;
	logic [ClassIdxW-1:0] bestIdx;
	actT bestScore;

	assign pop = (state == Idle) && !empty;
	assign weightBits = outputWeight(32'(classCnt), 32'(hiddenCnt));
	assign product = vecReg[hiddenCnt] * weightBits; // Low byte of the product
	assign classSum = acc + product;
	assign classScore = classSum[7] ? '0 : classSum;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
			classCnt <= '0;
			hiddenCnt <= '0;
			result <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= 1'b0;
			case (state)
				Idle:
				begin
					if (pop)
					begin
						classCnt <= '0;
						hiddenCnt <= '0;
						state <= Accum;
					end
				end
				Accum:
				begin
					hiddenCnt <= (hiddenCnt == LastHidden) ? '0 : hiddenCnt + 1'b1;
					if (hiddenCnt == LastHidden)
					begin
						classCnt <= classCnt + 1'b1;
						if (classCnt == LastClass)
							state <= Finish;
					end
				end
				Finish:
				begin
					result <= '{classIdx: bestIdx, score: bestScore};
					resultValid <= 1'b1;
					state <= Idle;
				end
				default: state <= Idle;
			endcase
		end
	end

	// Strict compare keeps the lowest class index on a tie
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			vecReg <= head;
			acc <= outputBias(0);
			bestIdx <= '0;
			bestScore <= '0;
		end
		else if (state == Accum)
		begin
			if (hiddenCnt == LastHidden)
			begin
				acc <= outputBias(32'(classCnt) + 1); // Seed for the next class
				if (classScore > bestScore)
				begin
					bestIdx <= classCnt;
					bestScore <= classScore;
				end
			end
			else
				acc <= classSum;
		end
	end

	// Pop cycle, one cycle per weight and the result cycle
	resultFollowsPop: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(pop, NumClasses * NumHidden + 2));

endmodule

//--- rtl/nnCore.sv
`timescale 1ns/1ps

module nnCore #(
	parameter int BufferDepth = 4
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::sampleT sample,
	input logic sampleStrobe,
	output nnTypesPkg::resultT result,
	output logic resultValid,
	output logic [7:0] dropCount
);
	import nnTypesPkg::*;

	frameT frame;
	logic frameValid;
	hiddenVecT hidden;
	logic hiddenValid;
	hiddenVecT head;
	logic empty;
	logic pop;

	sampleCollector collector0 (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleStrobe(sampleStrobe),
		.frame(frame),
		.frameValid(frameValid)
	);

	denseLayer layer0 (
		.clk(clk),
		.reset(reset),
		.frame(frame),
		.frameValid(frameValid),
		.hidden(hidden),
		.hiddenValid(hiddenValid)
	);

	activationBuffer #(
		.BufferDepth(BufferDepth)
	) buffer0 (
		.clk(clk),
		.reset(reset),
		.push(hiddenValid),
		.pushData(hidden),
		.pop(pop),
		.head(head),
		.empty(empty),
		.dropCount(dropCount)
	);

	outputClassifier classifier0 (
		.clk(clk),
		.reset(reset),
		.head(head),
		.empty(empty),
		.pop(pop),
		.result(result),
		.resultValid(resultValid)
	);

endmodule

//--- dv/nnModel.svh
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

function automatic actT reluByte(logic [7:0] sum);
	if (sum[7])
		return 8'h00;
	return sum;
endfunction

function automatic actT hiddenOut(frameT f, int n);
	logic [7:0] sum;
	logic [15:0] prod;
	sum = hiddenBias(n);
	for (int i = 0; i < NumInputs; i++)
	begin
		prod = f[i] * hiddenWeight(n, i);
		sum = sum + prod[7:0]; // Only the low byte of each product counts
	end
	return reluByte(sum);
endfunction

// Class 0 starts as the best, later classes must score strictly higher
function automatic resultT expectedResult(frameT f);
	hiddenVecT h;
	logic [7:0] sum;
	logic [15:0] prod;
	actT score;
	resultT best;
	for (int n = 0; n < NumHidden; n++)
		h[n] = hiddenOut(f, n);
	best = '0;
	for (int c = 0; c < NumClasses; c++)
	begin
		sum = outputBias(c);
		for (int j = 0; j < NumHidden; j++)
		begin
			prod = $signed({1'b0, h[j]}) * outputWeight(c, j);
			sum = sum + prod[7:0];
		end
		score = reluByte(sum);
		if (score > best.score)
		begin
			best.classIdx = ClassIdxW'(c);
			best.score = score;
		end
	end
	return best;
endfunction

`endif

//--- dv/nnCoreTb.sv
`timescale 1ns/1ps

module nnCoreTb;
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	`include "nnModel.svh"

	localparam int BufDepth = 4;
	localparam int GapFrames = 6;
	localparam int ExtremeFrames = 3;
	localparam int BackToBackFrames = 4;
	localparam int BurstFrames = 72; // Enough for the buffer to fill and overflow
	localparam int TotalFrames = GapFrames + ExtremeFrames + BackToBackFrames + BurstFrames;
	localparam int ScoreCycles = NumClasses * NumHidden;
	localparam int WatchdogCycles = TotalFrames * (ScoreCycles + 40) + 200;

	logic clk = 1'b0;
	logic reset;
	sampleT sample;
	logic sampleStrobe;
	resultT result;
	logic resultValid;
	logic [7:0] dropCount;

	logic [31:0] rngState = 32'h8de8_6889;
	resultT pendQ [$]; // Sent frames that have not reached the buffer yet
	resultT expQ [$]; // Accepted frames still waiting for their result
	int inCount;
	logic [3:0] pushPipe; // Last sample strobe to buffer push is four edges
	int mirrorOcc;
	int mirrorBusy;
	logic [7:0] expDrops;

	nnCore #(
		.BufferDepth(BufDepth)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleStrobe(sampleStrobe),
		.result(result),
		.resultValid(resultValid),
		.dropCount(dropCount)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stopRun(string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic valueError(string name, logic [31:0] got, logic [31:0] want);
		stopRun($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, want));
	endtask

	task automatic sendFrame(input bit extreme);
		frameT f;
		sampleT s;
		for (int i = 0; i < NumInputs; i++)
		begin
			@(posedge clk);
			rngState = xorshift(rngState);
			s = sampleT'(rngState[7:0]);
			if (extreme && rngState[9:8] == 2'd0)
				s = 8'sh80;
			else if (extreme && rngState[9:8] == 2'd1)
				s = 8'sh7F;
			sample <= s;
			sampleStrobe <= 1'b1;
			f[i] = s;
		end
		pendQ.push_back(expectedResult(f));
	endtask

	task automatic stopSamples();
		@(posedge clk);
		sampleStrobe <= 1'b0;
	endtask

	task automatic drainResults();
		while (pendQ.size() != 0 || expQ.size() != 0)
			@(posedge clk);
	endtask

	// Follows the buffer occupancy and classifier busy time to predict drops
	always @(posedge clk)
	begin
		logic last;
		logic popNow;
		logic pushNow;
		resultT frameRes;
		if (reset)
		begin
			inCount <= 0;
			pushPipe <= '0;
			mirrorOcc <= 0;
			mirrorBusy <= 0;
			expDrops <= '0;
		end
		else
		begin
			last = sampleStrobe && (inCount == NumInputs - 1);
			popNow = (mirrorBusy == 0) && (mirrorOcc != 0);
			pushNow = pushPipe[3] && (mirrorOcc < BufDepth || popNow);
			if (sampleStrobe)
				inCount <= last ? 0 : inCount + 1;
			pushPipe <= {pushPipe[2:0], last};
			if (pushPipe[3])
			begin
				frameRes = pendQ.pop_front();
				if (pushNow)
					expQ.push_back(frameRes);
				else
					expDrops <= expDrops + 8'd1;
			end
			mirrorOcc <= mirrorOcc + (pushNow ? 1 : 0) - (popNow ? 1 : 0);
			if (popNow)
				mirrorBusy <= ScoreCycles + 1; // Scoring cycles plus the result cycle
			else if (mirrorBusy != 0)
				mirrorBusy <= mirrorBusy - 1;
		end
	end

	always @(posedge clk)
	begin
		resultT expRes;
		if (!reset)
		begin
			assert (dropCount == expDrops)
				else valueError("dropCount", 32'(dropCount), 32'(expDrops));
			if (resultValid)
			begin
				assert (expQ.size() > 0)
					else stopRun("a result arrived with no accepted frame outstanding");
				expRes = expQ.pop_front();
				assert (result.classIdx == expRes.classIdx)
					else valueError("result.classIdx", 32'(result.classIdx), 32'(expRes.classIdx));
				assert (result.score == expRes.score)
					else valueError("result.score", 32'(result.score), 32'(expRes.score));
			end
		end
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		stopRun("watchdog timeout, the expected results did not all arrive");
	end

	initial
	begin
		reset = 1'b1;
		sample = '0;
		sampleStrobe = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		assert (resultValid == 1'b0)
			else valueError("resultValid", 32'(resultValid), 32'h0);
		assert (dropCount == 8'h00)
			else valueError("dropCount", 32'(dropCount), 32'h0);

		for (int k = 0; k < GapFrames; k++)
		begin
			sendFrame(1'b0);
			stopSamples();
			drainResults();
		end

		for (int k = 0; k < ExtremeFrames; k++)
		begin
			sendFrame(1'b1);
			stopSamples();
			drainResults();
		end

		repeat (BackToBackFrames) sendFrame(1'b0);
		stopSamples();
		drainResults();
		assert (dropCount == 8'h00)
			else valueError("dropCount", 32'(dropCount), 32'h0);

		repeat (BurstFrames) sendFrame(1'b0);
		stopSamples();
		drainResults();
		assert (expDrops > 0)
			else stopRun("the burst never overflowed the activation buffer");

		repeat (ScoreCycles + 4) @(posedge clk); // Room for a stray extra result
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- sources.f
+incdir+dv
rtl/nnTypesPkg.sv
rtl/nnWeightsPkg.sv
rtl/sampleCollector.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/activationBuffer.sv
rtl/outputClassifier.sv
rtl/nnCore.sv
dv/nnCoreTb.sv

//--- Makefile
TOP := nnCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
